// ==== design/wb_pkg.sv ====
/*
 * Bus-side definitions for the SRAM slave.
 * Wishbone classic single cycles only, so there are no cti/bte fields.
 * Addresses are byte addresses and data is one 32-bit word per cycle.
 */

package wb_pkg;

    localparam int WB_DATA_WIDTH = 32;
    localparam int WB_ADDR_WIDTH = 32;
    localparam int WB_SEL_WIDTH  = WB_DATA_WIDTH / 8;

    // master request, held stable until ack.
    typedef struct packed {
        logic                     cyc;
        logic                     stb;
        logic                     we;
        logic [WB_SEL_WIDTH-1:0]  sel;
        logic [WB_ADDR_WIDTH-1:0] addr;
        logic [WB_DATA_WIDTH-1:0] data;
    } wb_req_t;

    // slave response, ack is high for one cycle.
    typedef struct packed {
        logic                     ack;
        logic [WB_DATA_WIDTH-1:0] data;
    } wb_rsp_t;

endpackage

// ==== design/sram_pkg.sv ====
/*
 * SRAM-side definitions: geometry, window and access timing.
 * The window must be 2^(SRAM_ADDR_WIDTH+1) bytes and start word aligned.
 * SRAM_WAIT_CYCLES must be 2 or more.
 */

package sram_pkg;

    localparam int SRAM_ADDR_WIDTH = 20;
    localparam int SRAM_DATA_WIDTH = 16;
    localparam int SRAM_SEL_WIDTH  = SRAM_DATA_WIDTH / 8;

    localparam logic [31:0] SRAM_BASE_ADDR  = 32'h0000_0000;
    localparam logic [31:0] SRAM_SIZE_BYTES = 32'd1 << (SRAM_ADDR_WIDTH + 1);

    // clock cycles the strobes stay up for one half access.
    localparam int SRAM_WAIT_CYCLES = 2;
    localparam int SRAM_WAIT_WIDTH  = $clog2(SRAM_WAIT_CYCLES + 1);

    // all strobes are active low.
    typedef struct packed {
        logic                       ce_n;
        logic                       oe_n;
        logic                       we_n;
        logic                       ub_n;
        logic                       lb_n;
        logic [SRAM_ADDR_WIDTH-1:0] addr;
        logic [SRAM_DATA_WIDTH-1:0] dq;
    } sram_pins_t;

    typedef enum logic [1:0] {
        PHASE_IDLE,
        PHASE_LOW,
        PHASE_HIGH,
        PHASE_ACK
    } sram_phase_e;

endpackage

// ==== design/sram_wait_timer.sv ====
/*
 * Wait-state counter for one SRAM half access.
 * Done pulses SRAM_WAIT_CYCLES-1 cycles after start, which is the
 * last cycle of the half. A new start reloads the count.
 */

`timescale 1ns/1ps

module sram_wait_timer (
    input  logic clk,
    input  logic i_rst,

    input  logic i_start,
    output logic o_done
);

    import sram_pkg::*;

    logic [SRAM_WAIT_WIDTH-1:0] cnt_q;

    always_ff @(posedge clk) begin
        if (i_rst) begin
            cnt_q <= '0;
        end else if (i_start) begin
            cnt_q <= SRAM_WAIT_WIDTH'(SRAM_WAIT_CYCLES - 1);
        end else if (cnt_q != '0) begin
            cnt_q <= cnt_q - 1'b1;
        end
    end

    // zero means idle, so done stays low between accesses.
    assign o_done = (cnt_q == SRAM_WAIT_WIDTH'(1));

endmodule

// ==== design/sram_fsm.sv ====
/*
 * Access sequencer for the SRAM slave.
 * A request is taken in idle and walks low half, high half, then ack.
 * The first half is picked from the live select bits, later decisions
 * use the flags latched by the datapath. Out of range or empty selects
 * abort to ack in the first half cycle.
 */

`timescale 1ns/1ps

module sram_fsm (
    input  logic                  clk,
    input  logic                  i_rst,

    input  wb_pkg::wb_req_t       i_req,
    input  logic                  i_in_range,
    input  logic                  i_lo_used,
    input  logic                  i_hi_used,
    input  logic                  i_timer_done,

    output logic                  o_capture,
    output logic                  o_timer_start,
    output sram_pkg::sram_phase_e o_phase,
    output logic                  o_ack
);

    import wb_pkg::*;
    import sram_pkg::*;

    sram_phase_e state_q;
    sram_phase_e state_d;
    logic        start_q;
    logic        req_valid;
    logic        first_high;
    logic        enter_half;

    assign req_valid = i_req.cyc && i_req.stb;

    // skip straight to the high half when only upper bytes are selected.
    assign first_high = (i_req.sel[SRAM_SEL_WIDTH-1:0] == '0) &&
                        (i_req.sel[WB_SEL_WIDTH-1:SRAM_SEL_WIDTH] != '0);

    always_comb begin
        state_d = state_q;

        case (state_q)
            PHASE_IDLE: begin
                if (req_valid) begin
                    state_d = first_high ? PHASE_HIGH : PHASE_LOW;
                end
            end

            PHASE_LOW: begin
                if (!i_in_range || !i_lo_used) begin
                    state_d = PHASE_ACK;
                end else if (i_timer_done) begin
                    state_d = i_hi_used ? PHASE_HIGH : PHASE_ACK;
                end
            end

            PHASE_HIGH: begin
                if (!i_in_range || i_timer_done) begin
                    state_d = PHASE_ACK;
                end
            end

            PHASE_ACK: begin
                state_d = PHASE_IDLE;
            end

            default: begin
                state_d = PHASE_IDLE;
            end
        endcase
    end

    assign enter_half = (state_d != state_q) &&
                        ((state_d == PHASE_LOW) || (state_d == PHASE_HIGH));

    always_ff @(posedge clk) begin
        if (i_rst) begin
            state_q <= PHASE_IDLE;
            start_q <= 1'b0;
        end else begin
            state_q <= state_d;
            // timer starts in the first cycle of each half.
            start_q <= enter_half;
        end
    end

    assign o_capture     = (state_q == PHASE_IDLE) && req_valid;
    assign o_timer_start = start_q;
    assign o_phase       = state_q;
    assign o_ack         = (state_q == PHASE_ACK);

endmodule

// ==== design/sram_datapath.sv ====
/*
 * Request latch, SRAM pin generation and read word assembly.
 * Flags and pins are valid the cycle after capture.
 * Bytes that are not selected, not read, or out of range return zero.
 * Write data is driven on dq whenever the pins are active.
 */

`timescale 1ns/1ps

module sram_datapath (
    input  logic                                 clk,
    input  logic                                 i_rst,

    input  wb_pkg::wb_req_t                      i_req,
    input  logic                                 i_capture,
    input  sram_pkg::sram_phase_e                i_phase,
    input  logic                                 i_timer_done,
    input  logic [sram_pkg::SRAM_DATA_WIDTH-1:0] i_sram_dq,

    output logic                                 o_in_range,
    output logic                                 o_lo_used,
    output logic                                 o_hi_used,
    output sram_pkg::sram_pins_t                 o_sram,
    output logic [wb_pkg::WB_DATA_WIDTH-1:0]     o_rdata
);

    import wb_pkg::*;
    import sram_pkg::*;

    logic [WB_ADDR_WIDTH-1:0]   offset;
    logic                       we_q;
    logic [WB_SEL_WIDTH-1:0]    sel_q;
    logic [WB_DATA_WIDTH-1:0]   wdata_q;
    logic [SRAM_ADDR_WIDTH-2:0] word_q;
    logic                       hi_half;
    logic                       active;
    logic [SRAM_SEL_WIDTH-1:0]  half_sel;
    logic [SRAM_DATA_WIDTH-1:0] half_wdata;

    // wraps below the base, so one compare covers both ends.
    assign offset = i_req.addr - SRAM_BASE_ADDR;

    always_ff @(posedge clk) begin
        if (i_rst) begin
            o_in_range <= 1'b0;
            o_lo_used  <= 1'b0;
            o_hi_used  <= 1'b0;
        end else if (i_capture) begin
            o_in_range <= (offset < SRAM_SIZE_BYTES);
            o_lo_used  <= |i_req.sel[SRAM_SEL_WIDTH-1:0];
            o_hi_used  <= |i_req.sel[WB_SEL_WIDTH-1:SRAM_SEL_WIDTH];
        end
    end

    always_ff @(posedge clk) begin
        if (i_capture) begin
            we_q    <= i_req.we;
            sel_q   <= i_req.sel;
            wdata_q <= i_req.data;
            word_q  <= offset[SRAM_ADDR_WIDTH:2];
        end
    end

    assign hi_half = (i_phase == PHASE_HIGH);

    assign active = o_in_range &&
                    (((i_phase == PHASE_LOW) && o_lo_used) || (hi_half && o_hi_used));

    assign half_sel   = hi_half ? sel_q[WB_SEL_WIDTH-1:SRAM_SEL_WIDTH]
                                : sel_q[SRAM_SEL_WIDTH-1:0];
    assign half_wdata = hi_half ? wdata_q[WB_DATA_WIDTH-1:SRAM_DATA_WIDTH]
                                : wdata_q[SRAM_DATA_WIDTH-1:0];

    // sram word 2n holds the low half of bus word n.
    always_comb begin
        o_sram.ce_n = ~active;
        o_sram.oe_n = ~(active && !we_q);
        o_sram.we_n = ~(active && we_q);
        o_sram.ub_n = ~(active && half_sel[1]);
        o_sram.lb_n = ~(active && half_sel[0]);
        o_sram.addr = {word_q, hi_half};
        o_sram.dq   = half_wdata;
    end

    // sample dq in the last cycle of a read half.
    always_ff @(posedge clk) begin
        if (i_capture) begin
            o_rdata <= '0;
        end else if (active && !we_q && i_timer_done) begin
            for (int b = 0; b < SRAM_SEL_WIDTH; b++) begin
                if (half_sel[b]) begin
                    o_rdata[hi_half * SRAM_DATA_WIDTH + b * 8 +: 8] <= i_sram_dq[b * 8 +: 8];
                end
            end
        end
    end

endmodule

// ==== design/sram_top.sv ====
/*
 * Wishbone classic slave for an asynchronous 16-bit SRAM.
 * Each bus word takes up to two half accesses, low half first.
 * Out of range requests are acked with zero data and no SRAM cycle.
 * The master must drop stb for a cycle after ack.
 * dq is split into in and out words, the out word is valid while we_n is low.
 */

`timescale 1ns/1ps

module sram_top (
    input  logic                                 clk,
    input  logic                                 i_rst,

    // bus side
    input  wb_pkg::wb_req_t                      i_wb_req,
    output wb_pkg::wb_rsp_t                      o_wb_rsp,

    // sram side
    output sram_pkg::sram_pins_t                 o_sram,
    input  logic [sram_pkg::SRAM_DATA_WIDTH-1:0] i_sram_dq
);

    import wb_pkg::*;
    import sram_pkg::*;

    logic                     capture;
    logic                     timer_start;
    logic                     timer_done;
    logic                     in_range;
    logic                     lo_used;
    logic                     hi_used;
    logic                     ack;
    sram_phase_e              phase;
    logic [WB_DATA_WIDTH-1:0] rdata;

    sram_fsm sram_fsm_inst (
        .clk           (clk),
        .i_rst         (i_rst),
        .i_req         (i_wb_req),
        .i_in_range    (in_range),
        .i_lo_used     (lo_used),
        .i_hi_used     (hi_used),
        .i_timer_done  (timer_done),
        .o_capture     (capture),
        .o_timer_start (timer_start),
        .o_phase       (phase),
        .o_ack         (ack)
    );

    sram_wait_timer sram_wait_timer_inst (
        .clk     (clk),
        .i_rst   (i_rst),
        .i_start (timer_start),
        .o_done  (timer_done)
    );

    sram_datapath sram_datapath_inst (
        .clk          (clk),
        .i_rst        (i_rst),
        .i_req        (i_wb_req),
        .i_capture    (capture),
        .i_phase      (phase),
        .i_timer_done (timer_done),
        .i_sram_dq    (i_sram_dq),
        .o_in_range   (in_range),
        .o_lo_used    (lo_used),
        .o_hi_used    (hi_used),
        .o_sram       (o_sram),
        .o_rdata      (rdata)
    );

    assign o_wb_rsp = '{ack: ack, data: rdata};

endmodule

// ==== sim/sram_model.sv ====
/*
 * Behavioral asynchronous 16-bit SRAM with upper and lower byte enables.
 * Writes land at a rising clock edge while ce_n and we_n are low.
 * Reads are combinational while ce_n and oe_n are low, unselected bytes float.
 * Every location starts from a fill pattern of its whole address.
 */

`timescale 1ns/1ps

module sram_model (
    input  logic                                 clk,
    input  sram_pkg::sram_pins_t                 i_pins,
    output logic [sram_pkg::SRAM_DATA_WIDTH-1:0] o_dq
);

    import sram_pkg::*;

    localparam int DEPTH = 1 << SRAM_ADDR_WIDTH;

    logic [SRAM_DATA_WIDTH-1:0] mem [0:DEPTH-1];

    function automatic logic [SRAM_DATA_WIDTH-1:0] fill_pattern(
        input logic [SRAM_ADDR_WIDTH-1:0] a
    );
        return a[15:0] ^ {4{a[19:16]}} ^ 16'hA5C3;
    endfunction

    initial begin
        for (int a = 0; a < DEPTH; a++) begin
            mem[a] = fill_pattern(SRAM_ADDR_WIDTH'(a));
        end
    end

    always @(posedge clk) begin
        if (!i_pins.ce_n && !i_pins.we_n) begin
            if (!i_pins.lb_n) begin
                mem[i_pins.addr][7:0] <= i_pins.dq[7:0];
            end
            if (!i_pins.ub_n) begin
                mem[i_pins.addr][15:8] <= i_pins.dq[15:8];
            end
        end
    end

    always_comb begin
        o_dq = 'z;
        if (!i_pins.ce_n && !i_pins.oe_n) begin
            if (!i_pins.lb_n) begin
                o_dq[7:0] = mem[i_pins.addr][7:0];
            end
            if (!i_pins.ub_n) begin
                o_dq[15:8] = mem[i_pins.addr][15:8];
            end
        end
    end

endmodule

// ==== sim/tb_sram_top.sv ====
/*
 * Testbench for the Wishbone SRAM slave, acting as the bus master.
 * A reference copy of every written word is kept; words never written
 * read back as the model's address fill pattern.
 * Inputs change and outputs are sampled on the falling clock edge.
 * Random stimulus comes from $urandom with a fixed seed.
 */

`timescale 1ns/1ps

module tb_sram_top;

    import wb_pkg::*;
    import sram_pkg::*;

    localparam int          TIMEOUT_CYCLES = 3000;
    localparam int          RANDOM_CYCLES  = 250;
    localparam int          ACK_LIMIT      = 10;
    localparam int          WINDOW_WORDS   = SRAM_SIZE_BYTES / 4;
    localparam logic [31:0] RAND_SEED      = 32'h9708_9968;

    logic                       clk;
    logic                       rst;
    wb_req_t                    wb_req;
    wb_rsp_t                    wb_rsp;
    sram_pins_t                 sram_pins;
    logic [SRAM_DATA_WIDTH-1:0] sram_dq;

    logic [31:0] ref_mem [int unsigned];

    // bus cycle in flight as the pin monitor sees it.
    logic                       in_txn;
    logic                       monitor_on;
    logic                       cur_we;
    logic [WB_SEL_WIDTH-1:0]    cur_sel;
    logic [SRAM_ADDR_WIDTH-2:0] cur_word;
    logic [WB_DATA_WIDTH-1:0]   cur_wdata;
    int                         lo_cycles;
    int                         hi_cycles;
    int                         cycle_count = 0;
    int                         error_count = 0;

    sram_top UUT (
        .clk       (clk),
        .i_rst     (rst),
        .i_wb_req  (wb_req),
        .o_wb_rsp  (wb_rsp),
        .o_sram    (sram_pins),
        .i_sram_dq (sram_dq)
    );

    sram_model sram_mem (
        .clk    (clk),
        .i_pins (sram_pins),
        .o_dq   (sram_dq)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Error: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            stop_run();
        end
    end

    task automatic stop_run();
        error_count++;
        $display("TEST RESULT: FAIL");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic expect_bits(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        assert (act === exp) else begin
            $display("** Error at %0t ns: %s expected 0x%0h, actual 0x%0h",
                     $time, name, exp, act);
            stop_run();
        end
    endtask

    task automatic expect_true(input logic cond, input string what);
        assert (cond === 1'b1) else begin
            $display("Error at %0t ns: %s", $time, what);
            stop_run();
        end
    endtask

    function automatic logic [15:0] fill_pattern(input logic [19:0] a);
        return a[15:0] ^ {4{a[19:16]}} ^ 16'hA5C3;
    endfunction

    function automatic logic [31:0] ref_word(input int unsigned n);
        logic [19:0] base;
        base = 20'(n << 1);
        if (ref_mem.exists(n)) begin
            return ref_mem[n];
        end
        return {fill_pattern(base | 20'd1), fill_pattern(base)};
    endfunction

    // one sample of the pins while ce_n is low.
    task automatic check_half_access();
        logic                       half;
        logic [SRAM_SEL_WIDTH-1:0]  half_sel;
        logic [SRAM_DATA_WIDTH-1:0] half_data;
        half      = sram_pins.addr[0];
        half_sel  = half ? cur_sel[3:2] : cur_sel[1:0];
        half_data = half ? cur_wdata[31:16] : cur_wdata[15:0];
        expect_true(in_txn, "ce_n is low with no bus cycle in progress");
        expect_true(half_sel != '0, "SRAM access to a half with no byte selected");
        expect_true(half || (hi_cycles == 0), "low half accessed after the high half");
        expect_bits("o_sram.addr", {cur_word, half}, sram_pins.addr);
        expect_bits("o_sram.we_n", !cur_we, sram_pins.we_n);
        expect_bits("o_sram.oe_n", cur_we, sram_pins.oe_n);
        expect_bits("o_sram.ub_n", !half_sel[1], sram_pins.ub_n);
        expect_bits("o_sram.lb_n", !half_sel[0], sram_pins.lb_n);
        if (cur_we) begin
            expect_bits("o_sram.dq", half_data, sram_pins.dq);
        end
        if (half) begin
            hi_cycles++;
        end else begin
            lo_cycles++;
        end
    endtask

    always @(negedge clk) begin
        if (monitor_on) begin
            if (sram_pins.ce_n) begin
                expect_true(&{sram_pins.oe_n, sram_pins.we_n, sram_pins.ub_n, sram_pins.lb_n},
                            "an SRAM strobe is low while ce_n is high");
            end else begin
                check_half_access();
            end
        end
    end

    // one classic cycle checked against latency, pin activity and data rules.
    task automatic run_bus_cycle(input logic we, input logic [3:0] sel,
                                 input logic [31:0] addr, input logic [31:0] wdata);
        logic [31:0] offset;
        logic        in_range;
        logic        lo_used;
        logic        hi_used;
        int          halves;
        int          exp_lat;
        int          latency;
        logic [31:0] mask;
        logic [31:0] word_val;
        int unsigned word;
        offset   = addr - SRAM_BASE_ADDR;
        in_range = (addr >= SRAM_BASE_ADDR) && (offset < SRAM_SIZE_BYTES);
        word     = offset >> 2;
        lo_used  = |sel[1:0];
        hi_used  = |sel[3:2];
        halves   = int'(lo_used) + int'(hi_used);
        exp_lat  = (!in_range || halves == 0) ? 2 : 1 + SRAM_WAIT_CYCLES * halves;
        mask     = {{8{sel[3]}}, {8{sel[2]}}, {8{sel[1]}}, {8{sel[0]}}};

        @(negedge clk);
        expect_bits("o_wb_rsp.ack", 0, wb_rsp.ack);
        cur_we    = we;
        cur_sel   = sel;
        cur_word  = word[SRAM_ADDR_WIDTH-2:0];
        cur_wdata = wdata;
        lo_cycles = 0;
        hi_cycles = 0;
        in_txn    = 1'b1;
        wb_req    = '{cyc: 1'b1, stb: 1'b1, we: we, sel: sel, addr: addr, data: wdata};

        latency = 0;
        do begin
            @(negedge clk);
            latency++;
            expect_true(latency <= ACK_LIMIT, "no ack within the cycle limit of a request");
        end while (!wb_rsp.ack);
        wb_req.cyc = 1'b0;
        wb_req.stb = 1'b0;
        in_txn     = 1'b0;

        expect_bits("ack latency in cycles", exp_lat, latency);
        expect_bits("low half cycles with ce_n low",
                    (in_range && lo_used) ? SRAM_WAIT_CYCLES : 0, lo_cycles);
        expect_bits("high half cycles with ce_n low",
                    (in_range && hi_used) ? SRAM_WAIT_CYCLES : 0, hi_cycles);

        if (!in_range) begin
            expect_bits("o_wb_rsp.data", 0, wb_rsp.data);
        end else if (we) begin
            word_val = ref_word(word);
            for (int b = 0; b < 4; b++) begin
                if (sel[b]) begin
                    word_val[b*8 +: 8] = wdata[b*8 +: 8];
                end
            end
            ref_mem[word] = word_val;
            // word n sits at SRAM addresses 2n and 2n+1.
            expect_bits("sram_mem.mem[2n]", word_val[15:0], sram_mem.mem[{cur_word, 1'b0}]);
            expect_bits("sram_mem.mem[2n+1]", word_val[31:16], sram_mem.mem[{cur_word, 1'b1}]);
        end else begin
            expect_bits("o_wb_rsp.data", ref_word(word) & mask, wb_rsp.data);
        end
    endtask

    initial begin
        int unsigned idx;
        int unsigned word;
        logic        rand_we;
        logic [3:0]  rand_sel;
        logic [31:0] rand_data;

        clk        = 1'b0;
        rst        = 1'b1;
        wb_req     = '0;
        in_txn     = 1'b0;
        monitor_on = 1'b0;
        cur_we     = 1'b0;
        cur_sel    = '0;
        cur_word   = '0;
        cur_wdata  = '0;
        lo_cycles  = 0;
        hi_cycles  = 0;
        void'($urandom(RAND_SEED));

        repeat (10) @(posedge clk);
        @(negedge clk);
        rst        = 1'b0;
        monitor_on = 1'b1;

        // idle bus after reset.
        repeat (2) @(negedge clk);
        expect_bits("o_wb_rsp.ack", 0, wb_rsp.ack);
        expect_bits("o_sram.ce_n", 1, sram_pins.ce_n);
        expect_bits("o_sram.oe_n", 1, sram_pins.oe_n);
        expect_bits("o_sram.we_n", 1, sram_pins.we_n);
        expect_bits("o_sram.ub_n", 1, sram_pins.ub_n);
        expect_bits("o_sram.lb_n", 1, sram_pins.lb_n);

        // full words.
        run_bus_cycle(1'b1, 4'b1111, 32'h0000_0100, 32'hDEAD_BEEF);
        run_bus_cycle(1'b0, 4'b1111, 32'h0000_0100, 32'h0);

        // partial selects skip the unused half.
        run_bus_cycle(1'b1, 4'b0011, 32'h0000_0100, 32'h1234_5678);
        run_bus_cycle(1'b1, 4'b1000, 32'h0000_0100, 32'hA5C3_0F0F);
        run_bus_cycle(1'b0, 4'b1111, 32'h0000_0100, 32'h0);
        run_bus_cycle(1'b0, 4'b0100, 32'h0000_0100, 32'h0);
        run_bus_cycle(1'b0, 4'b0010, 32'h0000_0100, 32'h0);
        run_bus_cycle(1'b1, 4'b0000, 32'h0000_0104, 32'hFFFF_FFFF);
        run_bus_cycle(1'b0, 4'b0000, 32'h0000_0104, 32'h0);

        // window edges and a word never written.
        run_bus_cycle(1'b1, 4'b1111, SRAM_BASE_ADDR + SRAM_SIZE_BYTES - 4, 32'hC001_D00D);
        run_bus_cycle(1'b0, 4'b1111, SRAM_BASE_ADDR + SRAM_SIZE_BYTES - 4, 32'h0);
        run_bus_cycle(1'b0, 4'b1111, 32'h0000_8000, 32'h0);

        // outside the window.
        run_bus_cycle(1'b0, 4'b1111, SRAM_BASE_ADDR + SRAM_SIZE_BYTES, 32'h0);
        run_bus_cycle(1'b1, 4'b1111, SRAM_BASE_ADDR + SRAM_SIZE_BYTES, 32'h5555_AAAA);
        run_bus_cycle(1'b0, 4'b1111, 32'hFFFF_FFFC, 32'h0);

        // random traffic near both ends of the window.
        for (int i = 0; i < RANDOM_CYCLES; i++) begin
            idx       = $urandom % 16;
            word      = ($urandom % 2 != 0) ? idx : WINDOW_WORDS - 16 + idx;
            rand_we   = 1'($urandom);
            rand_sel  = 4'($urandom);
            rand_data = $urandom;
            run_bus_cycle(rand_we, rand_sel, SRAM_BASE_ADDR + (word << 2), rand_data);
        end

        @(negedge clk);
        if (error_count == 0) begin
            $display("TEST RESULT: PASS");
            $finish;
        end else begin
            stop_run();
        end
    end

endmodule

// ==== compile.f ====
design/wb_pkg.sv
design/sram_pkg.sv
design/sram_wait_timer.sv
design/sram_fsm.sv
design/sram_datapath.sv
design/sram_top.sv
sim/sram_model.sv
sim/tb_sram_top.sv
